//--- dv/pipe_ctrl_tb.sv
// --------------------
// pipeline control testbench
// directed hazard / trap phases, then lcg random cycles
// checked every edge against a reference model
// --------------------
`timescale 1ns/10ps

module pipe_ctrl_tb;

    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 200;  // generous bound on the directed phases
    localparam int RANDOM_CYCLES   = 2000;
    localparam int MAX_CYCLES      = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 790;

    // expected view of one cycle
    typedef struct packed {
        logic [5:0]                 ctrl;    // ifs ifl ems emf supi supd
        logic                       pc_en;
        pipe_ctrl_pkg::word_t       next_pc;
        logic                       trap;
        logic                       is_intr;
        pipe_ctrl_pkg::trap_cause_e cause;
        pipe_ctrl_pkg::word_t       epc;
    } ref_t;

    logic clk = 1'b0;
    logic reset;
    pipe_ctrl_pkg::reg_addr_t rs1_e, rs2_e, rd_m;
    logic reg_write, dren, dwen, csr_read, jump, branch, mispredict;
    logic i_mem_busy, d_mem_busy, ex_busy, halt, fence_stall, ifence, ret;
    logic intr_pending, valid_e, valid_m, insert_pc;
    pipe_ctrl_pkg::word_t pc_e, pc_m, branch_target, priv_pc, badaddr;
    logic fault_insn, mal_insn, illegal_insn, fault_l, mal_l, fault_s, mal_s;
    logic breakpoint, env;
    pipe_ctrl_pkg::word_t pc_f, trap_epc, trap_badaddr;
    logic if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush;
    logic suppress_iren, suppress_data, trap_valid, trap_is_intr;
    pipe_ctrl_pkg::trap_cause_e trap_cause;

    // model state, advanced once per rising edge
    pipe_ctrl_pkg::word_t       model_pc;
    logic                       model_tv;
    logic                       model_intr;
    pipe_ctrl_pkg::trap_cause_e model_cause;
    pipe_ctrl_pkg::word_t       model_epc;
    pipe_ctrl_pkg::word_t       model_bad;
    logic                       seen_trap;

    int          cycle_count = 0;
    int          checks_done = 0;
    int          fail_count  = 0;
    int          tests_run   = 0;
    int          tests_failed = 0;
    int          test_fail_base;
    string       cur_test;
    logic [31:0] lcg_state = 32'h322a_dfeb;

    pipe_ctrl_top dut_i (.*);

    always #4 clk = ~clk; // 8 ns period

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected outputs from the current inputs and the model pc
    function automatic ref_t ref_model(input pipe_ctrl_pkg::word_t cur_pc);
        ref_t r;
        logic exc, wdmem, wimem, bj, itake, roll, flush_haz, ctl;
        logic sup_i, mem_use, ems, ies;
        exc       = fault_insn | mal_insn | illegal_insn | fault_l | mal_l
                  | fault_s | mal_s | breakpoint | env;
        wdmem     = (dren | dwen) & d_mem_busy & ~exc; // suppressed access never waits
        bj        = jump | (branch & mispredict);
        itake     = intr_pending & ~exc & ~wdmem;
        roll      = ifence & ~fence_stall;
        flush_haz = exc | itake | ret | roll;
        ctl       = flush_haz | bj;
        sup_i     = bj | flush_haz | ret | insert_pc;
        wimem     = i_mem_busy & ~sup_i;
        mem_use   = reg_write & (dren | csr_read) & (rd_m != 5'd0)
                  & ((rs1_e == rd_m) | (rs2_e == rd_m));
        ems       = wdmem | fence_stall | halt;
        ies       = ems | (ex_busy & ~ctl) | mem_use | fence_stall;
        r.ctrl    = {ies, ctl | (wimem & ~ems), ems, ctl | (ies & ~ems), sup_i, exc};
        r.pc_en   = (~ies & ~wimem) | bj | flush_haz | insert_pc | ret;
        if (insert_pc) r.next_pc = priv_pc;
        else if (bj) r.next_pc = branch_target;
        else if (roll) r.next_pc = pc_e + 32'd4;
        else r.next_pc = cur_pc + 32'd4;
        r.trap    = exc | itake;
        r.is_intr = ~exc;
        if (!exc) r.cause = pipe_ctrl_pkg::cause_m_ext_irq;
        else if (breakpoint) r.cause = pipe_ctrl_pkg::breakpoint;
        else if (fault_insn) r.cause = pipe_ctrl_pkg::insn_fault;
        else if (mal_insn) r.cause = pipe_ctrl_pkg::insn_misaligned;
        else if (illegal_insn) r.cause = pipe_ctrl_pkg::illegal_insn;
        else if (env) r.cause = pipe_ctrl_pkg::env_call;
        else if (mal_l) r.cause = pipe_ctrl_pkg::load_misaligned;
        else if (mal_s) r.cause = pipe_ctrl_pkg::store_misaligned;
        else if (fault_l) r.cause = pipe_ctrl_pkg::load_fault;
        else r.cause = pipe_ctrl_pkg::store_fault;
        r.epc = (valid_m && (!itake || bj)) ? pc_m : (valid_e ? pc_e : cur_pc);
        return r;
    endfunction

    task automatic check_ctrl(input string name, input logic exp, input logic act);
        checks_done++;
        if (act !== exp) begin
            $display("MISMATCH @%0t %s: expected %b, actual %b", $time, name, exp, act);
            fail_count++;
        end
    endtask

    task automatic check_pc(input string name, input pipe_ctrl_pkg::word_t exp,
                            input pipe_ctrl_pkg::word_t act);
        checks_done++;
        if (act !== exp) begin
            $display("MISMATCH @%0t %s: expected %h, actual %h", $time, name, exp, act);
            fail_count++;
        end
    endtask

    // cause always, epc and badaddr only once a trap was captured
    task automatic check_trap(input pipe_ctrl_pkg::trap_cause_e exp_cause,
                              input pipe_ctrl_pkg::trap_cause_e act_cause,
                              input pipe_ctrl_pkg::word_t exp_epc,
                              input pipe_ctrl_pkg::word_t act_epc,
                              input pipe_ctrl_pkg::word_t exp_bad,
                              input pipe_ctrl_pkg::word_t act_bad,
                              input logic with_addr);
        checks_done++;
        if (act_cause !== exp_cause) begin
            $display("MISMATCH @%0t trap_cause: expected %0d, actual %0d",
                     $time, exp_cause, act_cause);
            fail_count++;
        end
        if (with_addr) begin
            check_pc("trap_epc", exp_epc, act_epc);
            check_pc("trap_badaddr", exp_bad, act_bad);
        end
    endtask

    // compare process, 1 ns after each rising edge
    always begin : compare_proc
        ref_t r;
        @(posedge clk);
        #1;
        if (reset) begin
            model_pc    = pipe_ctrl_pkg::RESET_PC;
            model_tv    = 1'b0;
            model_intr  = 1'b0;
            model_cause = pipe_ctrl_pkg::insn_misaligned;
            seen_trap   = 1'b0;
        end else begin
            r = ref_model(model_pc); // inputs unchanged since the falling edge
            check_ctrl("if_ex_stall", r.ctrl[5], if_ex_stall);
            check_ctrl("if_ex_flush", r.ctrl[4], if_ex_flush);
            check_ctrl("ex_mem_stall", r.ctrl[3], ex_mem_stall);
            check_ctrl("ex_mem_flush", r.ctrl[2], ex_mem_flush);
            check_ctrl("suppress_iren", r.ctrl[1], suppress_iren);
            check_ctrl("suppress_data", r.ctrl[0], suppress_data);
            if (r.pc_en) model_pc = r.next_pc;
            model_tv = r.trap;
            if (r.trap) begin
                model_cause = r.cause;
                model_intr  = r.is_intr;
                model_epc   = r.epc;
                model_bad   = badaddr;
                seen_trap   = 1'b1;
            end
            check_pc("pc_f", model_pc, pc_f);
            check_ctrl("trap_valid", model_tv, trap_valid);
            check_ctrl("trap_is_intr", model_intr, trap_is_intr);
            check_trap(model_cause, trap_cause, model_epc, trap_epc,
                       model_bad, trap_badaddr, seen_trap);
        end
    end

    task automatic set_quiet();
        {rs1_e, rs2_e, rd_m} = '0;
        {reg_write, dren, dwen, csr_read, jump, branch, mispredict} = '0;
        {i_mem_busy, d_mem_busy, ex_busy, halt, fence_stall, ifence, ret} = '0;
        {intr_pending, insert_pc} = '0;
        {fault_insn, mal_insn, illegal_insn, fault_l, mal_l, fault_s, mal_s} = '0;
        {breakpoint, env} = '0;
        valid_e       = 1'b1;
        valid_m       = 1'b1;
        pc_e          = 32'h0000_0400;
        pc_m          = 32'h0000_03fc;
        branch_target = 32'h0000_0800;
        priv_pc       = 32'h0000_0100;
        badaddr       = 32'h0;
    endtask

    // busy and exception inputs kept rare
    task automatic draw_random_inputs();
        logic [31:0] r0, r1, r2, r3, r4;
        lcg_state = lcg_next(lcg_state);
        r0 = lcg_state;
        lcg_state = lcg_next(lcg_state);
        r1 = lcg_state;
        lcg_state = lcg_next(lcg_state);
        r2 = lcg_state;
        lcg_state = lcg_next(lcg_state);
        r3 = lcg_state;
        lcg_state = lcg_next(lcg_state);
        r4 = lcg_state;
        rd_m       = r0[31:27];
        rs1_e      = (r0[16:15] == 2'b00) ? r0[31:27] : r0[26:22]; // force some matches
        rs2_e      = r0[21:17];
        reg_write  = r0[14];
        dren       = r0[13];
        dwen       = r0[12] & ~r0[13];
        csr_read   = (r0[11:10] == 2'b00);
        jump       = (r0[9:6] == 4'd0);
        branch     = r0[5];
        mispredict = r0[4];
        i_mem_busy   = (r1[31:29] == 3'd0);
        d_mem_busy   = (r1[28:26] == 3'd0);
        ex_busy      = (r1[25:23] == 3'd0);
        halt         = (r1[22:18] == 5'd0);
        fence_stall  = (r1[17:14] == 4'd0);
        ifence       = (r1[13:10] == 4'd0);
        ret          = (r1[9:6] == 4'd0);
        insert_pc    = (r1[5:2] == 4'd0);
        intr_pending = (r1[1:0] == 2'd0);
        {fault_insn, mal_insn, illegal_insn, fault_l, mal_l, fault_s, mal_s,
         breakpoint, env} = (r2[31:28] == 4'd0) ? r2[8:0] : 9'd0;
        valid_e       = r2[27] | r2[26];
        valid_m       = r2[25] | r2[24];
        pc_e          = {16'h0000, r3[15:2], 2'b00};
        pc_m          = {16'h0000, r3[31:18], 2'b00};
        branch_target = {r4[31:2], 2'b00};
        priv_pc       = {r4[15:2], r4[31:16], 2'b00};
        badaddr       = r3 ^ r4;
    endtask

    task automatic wait_trap(input int max_cycles);
        int waited;
        waited = 0;
        while (trap_valid !== 1'b1 && waited < max_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (trap_valid !== 1'b1) begin
            $display("no trap report within %0d cycles at %0t", max_cycles, $time);
            fail_count++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_fail_base = fail_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (fail_count == test_fail_base) begin
            $display("test %-20s ok", cur_test);
        end else begin
            $display("test %-20s %0d errors", cur_test, fail_count - test_fail_base);
            tests_failed++;
        end
    endtask

    initial begin
        wait (cycle_count >= MAX_CYCLES);
        $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        set_quiet();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        begin_test("reset_and_sequential");
        check_pc("pc_f", pipe_ctrl_pkg::RESET_PC, pc_f);
        check_ctrl("trap_valid", 1'b0, trap_valid);
        repeat (6) @(negedge clk);
        end_test();

        begin_test("load_use");
        rd_m = 5'd5;
        rs1_e = 5'd5;
        reg_write = 1'b1;
        dren = 1'b1;
        #1 check_ctrl("if_ex_stall", 1'b1, if_ex_stall);
        check_ctrl("ex_mem_flush", 1'b1, ex_mem_flush);
        @(negedge clk);
        rs1_e = 5'd0;
        rs2_e = 5'd5;       // dependency on rs2 side
        @(negedge clk);
        {rd_m, rs2_e} = '0; // x0 destination
        #1 check_ctrl("if_ex_stall", 1'b0, if_ex_stall);
        @(negedge clk);
        rd_m = 5'd7;
        rs1_e = 5'd7;
        dren = 1'b0;
        dwen = 1'b1;        // store, nothing to wait for
        #1 check_ctrl("if_ex_stall", 1'b0, if_ex_stall);
        @(negedge clk);
        set_quiet();
        end_test();

        begin_test("branch_and_redirect");
        branch = 1'b1;
        mispredict = 1'b1;
        branch_target = 32'h0000_1000;
        #1 check_ctrl("if_ex_flush", 1'b1, if_ex_flush);
        check_ctrl("ex_mem_flush", 1'b1, ex_mem_flush);
        check_ctrl("suppress_iren", 1'b1, suppress_iren);
        @(negedge clk);
        set_quiet();
        check_pc("pc_f", 32'h0000_1000, pc_f);
        jump = 1'b1;
        branch_target = 32'h0000_2000;
        @(negedge clk);
        set_quiet();
        check_pc("pc_f", 32'h0000_2000, pc_f);
        insert_pc = 1'b1;   // beats the branch below
        priv_pc = 32'h0000_0180;
        branch = 1'b1;
        mispredict = 1'b1;
        branch_target = 32'h0000_3000;
        @(negedge clk);
        set_quiet();
        check_pc("pc_f", 32'h0000_0180, pc_f);
        @(negedge clk);
        end_test();

        begin_test("memory_waits");
        dren = 1'b1;
        d_mem_busy = 1'b1;
        repeat (3) begin
            #1 check_ctrl("ex_mem_stall", 1'b1, ex_mem_stall);
            check_ctrl("if_ex_stall", 1'b1, if_ex_stall);
            @(negedge clk);
        end
        set_quiet();
        halt = 1'b1;
        repeat (2) @(negedge clk);
        set_quiet();
        fence_stall = 1'b1;
        repeat (2) @(negedge clk);
        set_quiet();
        i_mem_busy = 1'b1;  // fetch late, rest of pipe free
        #1 check_ctrl("if_ex_flush", 1'b1, if_ex_flush);
        check_ctrl("ex_mem_flush", 1'b0, ex_mem_flush);
        repeat (2) @(negedge clk);
        set_quiet();
        end_test();

        begin_test("exception_priority");
        mal_l = 1'b1;
        fault_s = 1'b1;
        env = 1'b1;
        pc_m = 32'h0000_0300;
        badaddr = 32'hdead_beef;
        #1 check_ctrl("suppress_data", 1'b1, suppress_data);
        @(negedge clk);
        set_quiet();
        wait_trap(4);
        check_ctrl("trap_is_intr", 1'b0, trap_is_intr);
        check_trap(pipe_ctrl_pkg::env_call, trap_cause, 32'h0000_0300, trap_epc,
                   32'hdead_beef, trap_badaddr, 1'b1);
        valid_m = 1'b0;     // epc falls back to pc_e
        pc_e = 32'h0000_0440;
        breakpoint = 1'b1;
        illegal_insn = 1'b1;
        badaddr = 32'h0000_1234;
        @(negedge clk);
        set_quiet();
        wait_trap(4);
        check_trap(pipe_ctrl_pkg::breakpoint, trap_cause, 32'h0000_0440, trap_epc,
                   32'h0000_1234, trap_badaddr, 1'b1);
        @(negedge clk);
        end_test();

        begin_test("interrupt_deferral");
        intr_pending = 1'b1;
        dren = 1'b1;
        d_mem_busy = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_ctrl("trap_valid", 1'b0, trap_valid); // held off by the load
        end
        d_mem_busy = 1'b0;
        @(negedge clk);
        set_quiet();
        wait_trap(4);
        check_ctrl("trap_is_intr", 1'b1, trap_is_intr);
        check_trap(pipe_ctrl_pkg::cause_m_ext_irq, trap_cause, 32'h0000_0400, trap_epc,
                   32'h0, trap_badaddr, 1'b1);
        @(negedge clk);
        end_test();

        begin_test("random");
        repeat (RANDOM_CYCLES) begin
            @(negedge clk);
            draw_random_inputs();
        end
        @(negedge clk);
        set_quiet();
        @(negedge clk);
        end_test();

        $display("tests %0d run, %0d failed; checks %0d, errors %0d",
                 tests_run, tests_failed, checks_done, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- hw/fetch_pc_unit.sv
// --------------------
// fetch pc unit
// fetch program counter, holds when disabled and
// otherwise loads the redirect picked by pc_src
// --------------------
`timescale 1ns/10ps

module fetch_pc_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pc_en,         // from hazard unit
    input  pipe_ctrl_pkg::pc_src_e pc_src,
    input  pipe_ctrl_pkg::word_t   priv_pc,       // trap vector or return target
    input  pipe_ctrl_pkg::word_t   branch_target,
    input  pipe_ctrl_pkg::word_t   pc_e,
    output pipe_ctrl_pkg::word_t   pc_f
);

    pipe_ctrl_pkg::word_t seq_pc;
    pipe_ctrl_pkg::word_t refetch_pc;
    pipe_ctrl_pkg::word_t next_pc;

    assign seq_pc     = pc_f + pipe_ctrl_pkg::INSN_BYTES;
    assign refetch_pc = pc_e + pipe_ctrl_pkg::INSN_BYTES; // insn after the fence.i

    // next pc mux
    always_comb begin
        case (pc_src)
            pipe_ctrl_pkg::src_priv: begin
                next_pc = priv_pc;
            end
            pipe_ctrl_pkg::src_branch: begin
                next_pc = branch_target;
            end
            pipe_ctrl_pkg::src_rollback: begin
                next_pc = refetch_pc;
            end
            default: begin
                next_pc = seq_pc;  // src_seq
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_f <= pipe_ctrl_pkg::RESET_PC;
        end else if (pc_en) begin
            pc_f <= next_pc;
        end
    end

    // alignment is kept as long as every chosen target is aligned,
    // both on load and on hold
    property p_pc_aligned;
        @(posedge clk) disable iff (reset)
        (pc_f[1:0] == 2'b00 && next_pc[1:0] == 2'b00) |=> (pc_f[1:0] == 2'b00);
    endproperty
    a_pc_aligned : assert property (p_pc_aligned)
        else $error("pc_f lost word alignment");

endmodule

//--- hw/pipe_ctrl_pkg.sv
// --------------------
// pipeline control package
// word and register index types, reset pc, trap cause
// and next-pc source encodings for the 3-stage core
// --------------------
package pipe_ctrl_pkg;

    typedef logic [31:0] word_t;     // pcs and addresses
    typedef logic [4:0]  reg_addr_t; // x0 means no destination

    // boot address of the fetch pc
    localparam word_t RESET_PC = 32'h0000_0200;

    // sequential fetch step, rv32i only so always one word
    localparam word_t INSN_BYTES = 32'd4;

    // mcause exception codes (interrupt bit travels separately)
    typedef enum logic [3:0] {
        insn_misaligned  = 4'd0,
        insn_fault       = 4'd1,
        illegal_insn     = 4'd2,
        breakpoint       = 4'd3,
        load_misaligned  = 4'd4,
        load_fault       = 4'd5,
        store_misaligned = 4'd6,
        store_fault      = 4'd7,
        env_call         = 4'd11  // ecall from m-mode
    } trap_cause_e;

    // machine external interrupt shares code 11 with ecall,
    // trap_is_intr tells the two apart
    localparam trap_cause_e cause_m_ext_irq = env_call;

    // where the fetch pc comes from next cycle
    typedef enum logic [1:0] {
        src_seq      = 2'd0, // pc_f + 4
        src_branch   = 2'd1, // resolved branch or jump target
        src_priv     = 2'd2, // trap vector or xret target
        src_rollback = 2'd3  // refetch after fence.i, pc_e + 4
    } pc_src_e;

endpackage

//--- hw/pipe_ctrl_top.sv
// --------------------
// pipeline control top
// hazard unit, trap cause encoder and fetch pc
// tied to the core's status and control ports
// --------------------
`timescale 1ns/10ps

module pipe_ctrl_top (
    input  logic                       clk,
    input  logic                       reset,
    // hazard inputs
    input  pipe_ctrl_pkg::reg_addr_t   rs1_e, rs2_e, rd_m,
    input  logic                       reg_write, dren, dwen, csr_read,
    input  logic                       jump, branch, mispredict,
    input  logic                       i_mem_busy, d_mem_busy, ex_busy,
    input  logic                       halt, fence_stall, ifence, ret,
    input  logic                       intr_pending, valid_e, valid_m,
    input  pipe_ctrl_pkg::word_t       pc_e, pc_m, branch_target,
    input  pipe_ctrl_pkg::word_t       priv_pc,
    input  logic                       insert_pc,
    input  pipe_ctrl_pkg::word_t       badaddr,
    // exception sources
    input  logic                       fault_insn, mal_insn, illegal_insn,
    input  logic                       fault_l, mal_l, fault_s, mal_s,
    input  logic                       breakpoint, env,
    // pipeline control
    output pipe_ctrl_pkg::word_t       pc_f,
    output logic                       if_ex_stall, if_ex_flush,
    output logic                       ex_mem_stall, ex_mem_flush,
    output logic                       suppress_iren, suppress_data,
    // trap report
    output logic                       trap_valid,
    output pipe_ctrl_pkg::trap_cause_e trap_cause,
    output logic                       trap_is_intr,
    output pipe_ctrl_pkg::word_t       trap_epc, trap_badaddr
);

    logic                   exception;  // encoder -> hazard unit
    logic                   intr_take;  // hazard unit -> encoder, pc unit
    logic                   pc_en;
    pipe_ctrl_pkg::pc_src_e pc_src;
    pipe_ctrl_pkg::word_t   epc;

    stage3_hazard_unit hazard_i (
        .clk, .reset,
        .rs1_e, .rs2_e, .rd_m, .reg_write, .dren, .dwen, .csr_read,
        .jump, .branch, .mispredict, .i_mem_busy, .d_mem_busy, .ex_busy,
        .halt, .fence_stall, .ifence, .ret, .insert_pc, .intr_pending,
        .exception, .valid_e, .valid_m, .pc_f, .pc_e, .pc_m,
        .if_ex_stall, .if_ex_flush, .ex_mem_stall, .ex_mem_flush,
        .suppress_iren, .suppress_data, .pc_en, .intr_take, .pc_src, .epc
    );

    trap_cause_encoder encoder_i (
        .clk, .reset,
        .fault_insn, .mal_insn, .illegal_insn, .fault_l, .mal_l,
        .fault_s, .mal_s, .breakpoint, .env, .intr_take,
        .epc, .badaddr, .exception,
        .trap_valid, .trap_cause, .trap_is_intr, .trap_epc, .trap_badaddr
    );

    fetch_pc_unit fetch_pc_i (
        .clk, .reset,
        .pc_en, .pc_src, .priv_pc, .branch_target, .pc_e,
        .pc_f
    );

endmodule

//--- hw/stage3_hazard_unit.sv
// --------------------
// stage3 hazard unit
// stall / flush control for the f/e and e/m registers,
// fetch pc enable and source, interrupt deferral and
// exception pc selection
// --------------------
`timescale 1ns/10ps

module stage3_hazard_unit (
    input  logic                     clk,   // assertions only
    input  logic                     reset, // assertions only
    // register dependencies
    input  pipe_ctrl_pkg::reg_addr_t rs1_e,
    input  pipe_ctrl_pkg::reg_addr_t rs2_e,
    input  pipe_ctrl_pkg::reg_addr_t rd_m,
    input  logic                     reg_write,
    input  logic                     dren,
    input  logic                     dwen,
    input  logic                     csr_read,
    // control flow
    input  logic                     jump,
    input  logic                     branch,
    input  logic                     mispredict,
    // slow units
    input  logic                     i_mem_busy,
    input  logic                     d_mem_busy,
    input  logic                     ex_busy,
    input  logic                     halt,
    input  logic                     fence_stall,
    input  logic                     ifence,
    // privileged events
    input  logic                     ret,
    input  logic                     insert_pc,
    input  logic                     intr_pending,
    input  logic                     exception,
    // stage occupancy and pcs
    input  logic                     valid_e,
    input  logic                     valid_m,
    input  pipe_ctrl_pkg::word_t     pc_f,
    input  pipe_ctrl_pkg::word_t     pc_e,
    input  pipe_ctrl_pkg::word_t     pc_m,
    // pipeline control
    output logic                     if_ex_stall,
    output logic                     if_ex_flush,
    output logic                     ex_mem_stall,
    output logic                     ex_mem_flush,
    output logic                     suppress_iren,
    output logic                     suppress_data,
    output logic                     pc_en,
    output logic                     intr_take,
    output pipe_ctrl_pkg::pc_src_e   pc_src,
    output pipe_ctrl_pkg::word_t     epc
);

    logic rs1_match;
    logic rs2_match;
    logic cannot_forward;
    logic mem_use_stall;
    logic dmem_access;
    logic wait_for_imem;
    logic wait_for_dmem;
    logic branch_jump;
    logic rollback;
    logic ex_flush_hazard;
    logic control_hazard;

    // data hazards, x0 never creates a dependency
    assign rs1_match      = (rs1_e == rd_m) && (rd_m != '0);
    assign rs2_match      = (rs2_e == rd_m) && (rd_m != '0);
    assign cannot_forward = dren || csr_read; // value only exists after mem stage
    assign mem_use_stall  = reg_write && cannot_forward && (rs1_match || rs2_match);

    // memory waits, ignored once the request is being suppressed
    assign dmem_access   = dren || dwen;
    assign wait_for_imem = i_mem_busy && !suppress_iren;
    assign wait_for_dmem = dmem_access && d_mem_busy && !suppress_data;

    assign branch_jump = jump || (branch && mispredict);

    // interrupt waits for an outstanding data access to finish,
    // exceptions always take priority
    assign intr_take = intr_pending && !exception && !wait_for_dmem;

    // fence.i redirects only once the cache flush is done
    assign rollback        = ifence && !fence_stall;
    assign ex_flush_hazard = exception || intr_take || ret || rollback;
    assign control_hazard  = ex_flush_hazard || branch_jump;

    // mem stage blocked, so everything behind it holds
    assign ex_mem_stall = wait_for_dmem
                       || fence_stall
                       || halt;

    assign if_ex_stall = ex_mem_stall                       // downstream held
                      || (ex_busy && !control_hazard)       // multicycle op, unless redirected
                      || mem_use_stall                      // load/csr result not forwardable
                      || fence_stall;

    // bubble into e when fetch lags but the rest moves on
    assign if_ex_flush = control_hazard
                      || (wait_for_imem && !ex_mem_stall);

    // bubble into m while e holds its instruction
    assign ex_mem_flush = control_hazard
                       || (if_ex_stall && !ex_mem_stall);

    // no new fetch request when a redirect is about to land
    assign suppress_iren = branch_jump || ex_flush_hazard || ret || insert_pc;
    assign suppress_data = exception; // keep the faulting access off the bus

    // pc moves when fetch can hand off, or on any forced redirect
    assign pc_en = (!if_ex_stall && !wait_for_imem)
                || branch_jump
                || ex_flush_hazard
                || insert_pc
                || ret;

    always_comb begin
        if (insert_pc) begin
            pc_src = pipe_ctrl_pkg::src_priv;     // trap entry / xret wins
        end else if (branch_jump) begin
            pc_src = pipe_ctrl_pkg::src_branch;
        end else if (rollback) begin
            pc_src = pipe_ctrl_pkg::src_rollback;
        end else begin
            pc_src = pipe_ctrl_pkg::src_seq;
        end
    end

    // oldest valid instruction is the one that traps;
    // an interrupt lets the m-stage insn retire unless it redirects
    assign epc = (valid_m && (!intr_take || branch_jump)) ? pc_m :
                 (valid_e ? pc_e : pc_f);

    // stalling e/m always stalls f/e as well
    property p_stall_order;
        @(posedge clk) disable iff (reset)
        ex_mem_stall |-> if_ex_stall;
    endproperty
    a_stall_order : assert property (p_stall_order)
        else $error("ex_mem_stall high while if_ex_stall low");

    // a held e/m register is only flushed by a redirect, never by
    // the bubble path of a f/e stall
    property p_flush_vs_stall;
        @(posedge clk) disable iff (reset)
        (ex_mem_stall && ex_mem_flush) |-> control_hazard;
    endproperty
    a_flush_vs_stall : assert property (p_flush_vs_stall)
        else $error("ex_mem_flush with ex_mem_stall and no control hazard");

endmodule

//--- hw/trap_cause_encoder.sv
// --------------------
// trap cause encoder
// priority-encodes exception sources into an mcause code
// and registers a one-cycle trap report for the priv unit
// --------------------
`timescale 1ns/10ps

module trap_cause_encoder (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fault_insn,
    input  logic                       mal_insn,
    input  logic                       illegal_insn,
    input  logic                       fault_l,
    input  logic                       mal_l,
    input  logic                       fault_s,
    input  logic                       mal_s,
    input  logic                       breakpoint,
    input  logic                       env,
    input  logic                       intr_take,   // interrupt accepted this cycle
    input  pipe_ctrl_pkg::word_t       epc,
    input  pipe_ctrl_pkg::word_t       badaddr,
    output logic                       exception,   // any source active
    output logic                       trap_valid,
    output pipe_ctrl_pkg::trap_cause_e trap_cause,
    output logic                       trap_is_intr,
    output pipe_ctrl_pkg::word_t       trap_epc,
    output pipe_ctrl_pkg::word_t       trap_badaddr
);

    pipe_ctrl_pkg::trap_cause_e exc_cause;
    logic                       trap_taken;

    assign exception = fault_insn | mal_insn | illegal_insn
                     | fault_l | mal_l | fault_s | mal_s
                     | breakpoint | env;

    assign trap_taken = exception || intr_take;

    // fixed priority, highest first
    always_comb begin
        if (breakpoint) begin
            exc_cause = pipe_ctrl_pkg::breakpoint;
        end else if (fault_insn) begin
            exc_cause = pipe_ctrl_pkg::insn_fault;
        end else if (mal_insn) begin
            exc_cause = pipe_ctrl_pkg::insn_misaligned;
        end else if (illegal_insn) begin
            exc_cause = pipe_ctrl_pkg::illegal_insn;
        end else if (env) begin
            exc_cause = pipe_ctrl_pkg::env_call;
        end else if (mal_l) begin
            exc_cause = pipe_ctrl_pkg::load_misaligned;
        end else if (mal_s) begin
            exc_cause = pipe_ctrl_pkg::store_misaligned;
        end else if (fault_l) begin
            exc_cause = pipe_ctrl_pkg::load_fault;
        end else begin
            exc_cause = pipe_ctrl_pkg::store_fault; // only fault_s left
        end
    end

    // strobe plus cause, held until the next trap
    always_ff @(posedge clk) begin
        if (reset) begin
            trap_valid   <= 1'b0;
            trap_cause   <= pipe_ctrl_pkg::insn_misaligned;
            trap_is_intr <= 1'b0;
        end else begin
            trap_valid <= trap_taken; // single pulse, no back-pressure
            if (trap_taken) begin
                trap_cause   <= exception ? exc_cause : pipe_ctrl_pkg::cause_m_ext_irq;
                trap_is_intr <= !exception;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trap_taken) begin
            trap_epc     <= epc;
            trap_badaddr <= badaddr;
        end
    end

    // back-to-back pulses only when each cycle took its own trap
    property p_single_pulse;
        @(posedge clk) disable iff (reset)
        (trap_valid && $past(trap_valid)) |-> $past(trap_taken);
    endproperty
    a_single_pulse : assert property (p_single_pulse)
        else $error("trap_valid held without a new trap");

endmodule

//--- pipe_ctrl_top.f
hw/pipe_ctrl_pkg.sv
hw/stage3_hazard_unit.sv
hw/trap_cause_encoder.sv
hw/fetch_pc_unit.sv
hw/pipe_ctrl_top.sv
dv/pipe_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the pipeline control testbench with verilator and run it;
# the run fails if the log reports a failure or the build breaks
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert -f pipe_ctrl_top.f \
    --top-module pipe_ctrl_tb -o pipe_ctrl_sim \
    && ./obj_dir/pipe_ctrl_sim > "$LOG" 2>&1 \
    ; cat "$LOG" \
    && ! grep -qF "*** FAILED ***" "$LOG" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
